//--- src.f
+incdir+.
smu_pkg.sv
spi_frame_rx.sv
ctrl_reg_file.sv
periph_spi_mux.sv
smu_ctrl_top.sv
tb_smu_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# build the smu control testbench with verilator and run it into a log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f src.f --top-module tb_smu_ctrl -Mdir "$OBJ" -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "simulation passed"
exit 0

//--- tb_smu_ctrl_tasks.svh
/*
  testbench helpers for the smu control testbench
  lfsr stimulus, spi frame driving and typed compares
*/
`ifndef TB_SMU_CTRL_TASKS_SVH
`define TB_SMU_CTRL_TASKS_SVH

  //////////////////////////////////////////////////
  // random stimulus

  // 16-bit galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] nxt;
    nxt = {1'b0, s[15:1]};
    if (s[0])
      nxt = nxt ^ 16'hB400;
    return nxt;
  endfunction

  // one lfsr step per bit, first bit lands in the msb
  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
  endtask

  task automatic rand_reg_addr(output logic [7:0] addr);
    logic [31:0] r;
    int          idx;
    rand_bits(5, r);
    idx  = int'(r[4:0]) % 18;
    addr = VALID_ADDRS[idx];
  endtask

  //////////////////////////////////////////////////
  // spi host

  // sends bits[16] first, nbits in all, sck at clk/8
  // called on a falling clk edge
  task automatic shift_bits(input logic [16:0] bits, input int nbits);
    cs_n = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      // host changes mosi while sck is low
      mosi = bits[16 - i];
      repeat (4) @(negedge clk);
      // reply bit settled since the last falling sck
      if (i < 16 && cs2_n)
        check_bit("miso", miso, REPLY_WORD[15 - i]);
      sck = 1'b1;
      repeat (4) @(negedge clk);
      sck = 1'b0;
    end
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
  endtask

  // model first, so the compare after cs_n rise sees the new state
  task automatic send_frame(input logic [7:0] addr, input logic [7:0] val, input int nbits);
    exp_regs = ref_model(exp_regs, addr, val, nbits);
    shift_bits({addr, val, 1'b1}, nbits);
    frames_sent++;
    // idle gap longer than the compare delay
    repeat (12) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // typed compares

  task automatic check_regs(input string name, input smu_pkg::ctrl_regs_t got,
                            input smu_pkg::ctrl_regs_t exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_cs(input string name, input logic [smu_pkg::NUM_PERIPH-1:0] got,
                          input logic [smu_pkg::NUM_PERIPH-1:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

`endif

//--- tb_smu_ctrl.sv
/*
  testbench for the smu control top level
  spi register writes against a reference model, reply word,
  frame discard rules and the cs2 peripheral mux
*/
`timescale 1ns/1ps

module tb_smu_ctrl;

  //////////////////////////////////////////////////
  // run length

  localparam int CLK_HALF       = 4;
  localparam int RESET_CYCLES   = 16;
  // cs setup, up to 17 sck periods of 8 clk, cs hold, idle gap
  localparam int FRAME_CYCLES   = 4 + 17 * 8 + 4 + 12;
  localparam int RAND_FRAMES    = 200;
  localparam int PRE_RST_WRITES = 20;
  localparam int MUX_ROUNDS     = 8;
  localparam int MISO_PATTERNS  = 16;
  // random, four discarded, writes before soft reset, soft reset, select writes
  localparam int NUM_FRAMES     = RAND_FRAMES + 4 + PRE_RST_WRITES + 1 + MUX_ROUNDS;
  localparam int MUX_CYCLES     = MUX_ROUNDS * (MISO_PATTERNS + 4);
  localparam int TIMEOUT_CYCLES =
    (RESET_CYCLES + 4 + NUM_FRAMES * FRAME_CYCLES + MUX_CYCLES) * 3 / 2;

  // fixed reply word with the msb on the wire first
  localparam logic [15:0] REPLY_WORD = 16'hFF00;
  // writable register addresses without the soft reset
  localparam logic [7:0] VALID_ADDRS [18] = '{
    8'd7, 8'd8, 8'd9, 8'd10, 8'd12, 8'd14, 8'd15, 8'd16, 8'd17,
    8'd18, 8'd24, 8'd25, 8'd28, 8'd29, 8'd30, 8'd31, 8'd32, 8'd33
  };

  logic                           clk;
  logic                           rst_n;
  logic                           sck;
  logic                           cs_n;
  logic                           mosi;
  logic                           cs2_n;
  logic [smu_pkg::NUM_PERIPH-1:0] periph_miso;
  logic                           miso;
  logic                           periph_sck;
  logic                           periph_mosi;
  logic [smu_pkg::NUM_PERIPH-1:0] periph_cs_n;
  smu_pkg::ctrl_regs_t            regs;

  // model state and bookkeeping
  smu_pkg::ctrl_regs_t exp_regs;
  logic [15:0]         lfsr_state;
  int                  frames_sent;
  int                  frames_checked;
  int                  cycle_cnt;

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////////////////////////
  // reference model

  // overlap in the masks turns the whole frame into a pure toggle per bit
  function automatic smu_pkg::ctrl_nib_t ref_update(input smu_pkg::ctrl_nib_t old,
                                                   input logic [7:0] val);
    smu_pkg::ctrl_nib_t res;
    logic               overlap;
    overlap = |(val[3:0] & val[7:4]);
    for (int b = 0; b < 4; b++)
    begin
      if (overlap)
        res[b] = (val[b] && val[b + 4]) ? ~old[b] : old[b];
      else if (val[b])
        res[b] = 1'b1;
      else if (val[b + 4])
        res[b] = 1'b0;
      else
        res[b] = old[b];
    end
    return res;
  endfunction

  // board-safe state
  function automatic smu_pkg::ctrl_regs_t ref_defaults();
    smu_pkg::ctrl_regs_t d;
    d                  = '0;
    d.dac_ref_mux      = 4'hF;
    d.clamp1           = 4'hF;
    d.clamp2           = 4'hF;
    d.rails_oe         = 4'h1;
    d.ina_ifb_sw       = 4'hF;
    d.ina_vfb_atten_sw = 4'hF;
    d.isense_mux       = 4'hF;
    return d;
  endfunction

  // next model state for one frame of nbits bits
  function automatic smu_pkg::ctrl_regs_t ref_model(input smu_pkg::ctrl_regs_t cur,
                                                   input logic [7:0] addr,
                                                   input logic [7:0] val,
                                                   input int nbits);
    smu_pkg::ctrl_regs_t nxt;
    nxt = cur;
    // a frame of the wrong length never reaches the registers
    if (nbits != 16)
      return cur;
    case (addr)
      8'd7:  nxt.led              = ref_update(cur.led, val);
      8'd8:  nxt.periph_sel       = ref_update(cur.periph_sel, val);
      8'd9:  nxt.dac              = ref_update(cur.dac, val);
      8'd10: nxt.rails            = ref_update(cur.rails, val);
      8'd11: nxt                  = ref_defaults();
      8'd12: nxt.dac_ref_mux      = ref_update(cur.dac_ref_mux, val);
      8'd14: nxt.adc              = ref_update(cur.adc, val);
      8'd15: nxt.clamp1           = ref_update(cur.clamp1, val);
      8'd16: nxt.clamp2           = ref_update(cur.clamp2, val);
      8'd17: nxt.relay_com        = ref_update(cur.relay_com, val);
      8'd18: nxt.irange_x_sw      = ref_update(cur.irange_x_sw, val);
      8'd24: nxt.rails_oe         = ref_update(cur.rails_oe, val);
      8'd25: nxt.ina_vfb_sw       = ref_update(cur.ina_vfb_sw, val);
      8'd28: nxt.ina_ifb_sw       = ref_update(cur.ina_ifb_sw, val);
      8'd29: nxt.ina_vfb_atten_sw = ref_update(cur.ina_vfb_atten_sw, val);
      8'd30: nxt.isense_mux       = ref_update(cur.isense_mux, val);
      8'd31: nxt.relay_out        = ref_update(cur.relay_out, val);
      8'd32: nxt.relay_vsense     = ref_update(cur.relay_vsense, val);
      8'd33: nxt.irange_yz_sw     = ref_update(cur.irange_yz_sw, val);
      default: nxt = cur;
    endcase
    return nxt;
  endfunction

`include "tb_smu_ctrl_tasks.svh"

  smu_ctrl_top i_smu_ctrl_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .miso        (miso),
    .periph_sck  (periph_sck),
    .periph_mosi (periph_mosi),
    .periph_cs_n (periph_cs_n),
    .periph_miso (periph_miso),
    .regs        (regs)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #CLK_HALF clk = ~clk;
    end
  end

  //////////////////////////////////////////////////
  // compare and timeout

  // register bank settles well inside 8 clk after cs_n rises
  initial
  begin
    frames_checked = 0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(posedge cs_n);
      repeat (8) @(negedge clk);
      check_regs("regs", regs, exp_regs);
      frames_checked++;
    end
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d clk cycles, test sequence did not finish", cycle_cnt);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [7:0]  addr;
    logic [31:0] r;
    rst_n       = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    cs2_n       = 1'b1;
    periph_miso = '0;
    lfsr_state  = 16'd15239;
    exp_regs    = ref_defaults();
    frames_sent = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // no reply word is loaded after reset so miso idles low
    check_regs("regs", regs, ref_defaults());
    check_cs("periph_cs_n", periph_cs_n, '1);
    check_bit("miso", miso, 1'b0);

    // random register writes
    repeat (RAND_FRAMES)
    begin
      rand_reg_addr(addr);
      rand_bits(8, r);
      send_frame(addr, r[7:0], 16);
    end

    // unknown, short and long frames are dropped
    // every one of them toggles a register if it is taken
    // unknown frames end on a 0 so the short frame lands on the dac register
    send_frame(8'd13, 8'hEE, 16);
    send_frame(8'd40, 8'hEE, 16);
    send_frame(8'd18, 8'h22, 15);
    send_frame(8'd9, 8'h11, 17);

    // soft reset after some more writes
    repeat (PRE_RST_WRITES)
    begin
      rand_reg_addr(addr);
      rand_bits(8, r);
      send_frame(addr, r[7:0], 16);
    end
    if (exp_regs === ref_defaults())
    begin
      $display("random writes left the registers at their defaults before the soft reset");
      stop_on_error();
    end
    rand_bits(8, r);
    send_frame(8'd11, r[7:0], 16);
    check_regs("regs", regs, ref_defaults());

    // downstream mux through cs2
    repeat (MUX_ROUNDS)
    begin
      rand_bits(8, r);
      send_frame(8'd8, r[7:0], 16);
      cs2_n = 1'b0;
      @(negedge clk);
      check_cs("periph_cs_n", periph_cs_n, ~exp_regs.periph_sel[smu_pkg::NUM_PERIPH-1:0]);
      repeat (MISO_PATTERNS)
      begin
        rand_bits(6, r);
        periph_miso = r[3:0];
        sck         = r[4];
        mosi        = r[5];
        @(negedge clk);
        check_bit("miso", miso, |(exp_regs.periph_sel[3:0] & r[3:0]));
        check_bit("periph_sck", periph_sck, r[4]);
        check_bit("periph_mosi", periph_mosi, r[5]);
      end
      sck   = 1'b0;
      mosi  = 1'b0;
      cs2_n = 1'b1;
      @(negedge clk);
      check_cs("periph_cs_n", periph_cs_n, '1);
    end

    if (frames_checked == frames_sent)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      $display("compare process checked %0d of %0d frames", frames_checked, frames_sent);
      $display("TEST FAILED");
      $fatal(1, "frame count differs");
    end
  end

endmodule

//--- smu_ctrl_top.sv
/*
  smu board control top level
  spi register interface to the board control lines, plus the
  cs2 pass-through to the downstream spi peripherals
*/
`timescale 1ns/1ps

module smu_ctrl_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // host spi
  input  logic                           sck,
  input  logic                           cs_n,
  input  logic                           mosi,
  input  logic                           cs2_n,
  output logic                           miso,
  // downstream spi
  output logic                           periph_sck,
  output logic                           periph_mosi,
  output logic [smu_pkg::NUM_PERIPH-1:0] periph_cs_n,
  input  logic [smu_pkg::NUM_PERIPH-1:0] periph_miso,
  // control registers, mapped to pins by the board wrapper
  output smu_pkg::ctrl_regs_t            regs
);

  smu_pkg::spi_frame_t frame;
  logic                frame_valid;
  logic                reply_bit;

  // sck and mosi fan out to every peripheral unchanged
  assign periph_sck  = sck;
  assign periph_mosi = mosi;

  //////////////////////////////////////////////////
  // register path

  spi_frame_rx i_spi_frame_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .frame       (frame),
    .frame_valid (frame_valid),
    .reply_bit   (reply_bit)
  );

  ctrl_reg_file i_ctrl_reg_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .regs        (regs)
  );

  //////////////////////////////////////////////////
  // peripheral routing

  periph_spi_mux i_periph_spi_mux (
    .cs2_n       (cs2_n),
    .periph_sel  (regs.periph_sel),
    .reply_bit   (reply_bit),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

//--- periph_spi_mux.sv
/*
  downstream spi mux
  cs2_n gates the peripheral chip selects picked by periph_sel
  and chooses which device drives the shared miso line
*/
`timescale 1ns/1ps

module periph_spi_mux (
  input  logic                          cs2_n,
  input  smu_pkg::ctrl_nib_t            periph_sel,
  input  logic                          reply_bit,
  input  logic [smu_pkg::NUM_PERIPH-1:0] periph_miso,
  output logic [smu_pkg::NUM_PERIPH-1:0] periph_cs_n,
  output logic                          miso
);

  // one select bit per downstream device
  logic [smu_pkg::NUM_PERIPH-1:0] sel;
  logic [smu_pkg::NUM_PERIPH-1:0] sel_miso;

  assign sel      = periph_sel[smu_pkg::NUM_PERIPH-1:0];
  assign sel_miso = sel & periph_miso;

  //////////////////////////////////////////////////
  // chip select and miso

  // no clk here, downstream traffic runs at sck only
  always_comb
  begin
    if (cs2_n)
    begin
      // cs2 idle so every device deselected
      // fpga reply word owns miso
      periph_cs_n = '1;
      miso        = reply_bit;
    end
    else
    begin
      // selected devices see cs asserted low
      periph_cs_n = ~sel;
      // any selected device pulling high wins
      miso        = |sel_miso;
    end
  end

endmodule

//--- ctrl_reg_file.sv
/*
  control register file
  eighteen 4-bit board control registers, written by spi frames with
  set/clear/toggle masks, plus a soft reset back to safe defaults
*/
`timescale 1ns/1ps

module ctrl_reg_file (
  input  logic                clk,
  input  logic                rst_n,
  input  smu_pkg::spi_frame_t frame,
  input  logic                frame_valid,
  output smu_pkg::ctrl_regs_t regs
);

  smu_pkg::ctrl_regs_t regs_q;
  smu_pkg::ctrl_regs_t regs_d;
  smu_pkg::reg_addr_e  addr;

  // high byte decoded as an address
  assign addr = smu_pkg::reg_addr_e'(frame.addr);

  //////////////////////////////////////////////////
  // next state

  always_comb
  begin
    regs_d = regs_q;
    if (frame_valid)
    begin
      case (addr)
        smu_pkg::addr_led:
          regs_d.led = smu_pkg::apply_update(regs_q.led, frame.val);
        // selects downstream cs2 target
        smu_pkg::addr_periph_sel:
          regs_d.periph_sel = smu_pkg::apply_update(regs_q.periph_sel, frame.val);
        smu_pkg::addr_dac:
          regs_d.dac = smu_pkg::apply_update(regs_q.dac, frame.val);
        smu_pkg::addr_rails:
          regs_d.rails = smu_pkg::apply_update(regs_q.rails, frame.val);
        // whole bank back to board-safe state
        smu_pkg::addr_soft_reset:
          regs_d = smu_pkg::CTRL_DEFAULTS;
        smu_pkg::addr_dac_ref_mux:
          regs_d.dac_ref_mux = smu_pkg::apply_update(regs_q.dac_ref_mux, frame.val);
        smu_pkg::addr_adc:
          regs_d.adc = smu_pkg::apply_update(regs_q.adc, frame.val);
        // clamps
        smu_pkg::addr_clamp1:
          regs_d.clamp1 = smu_pkg::apply_update(regs_q.clamp1, frame.val);
        smu_pkg::addr_clamp2:
          regs_d.clamp2 = smu_pkg::apply_update(regs_q.clamp2, frame.val);
        smu_pkg::addr_relay_com:
          regs_d.relay_com = smu_pkg::apply_update(regs_q.relay_com, frame.val);
        smu_pkg::addr_irange_x_sw:
          regs_d.irange_x_sw = smu_pkg::apply_update(regs_q.irange_x_sw, frame.val);
        // rail output enable is active low
        smu_pkg::addr_rails_oe:
          regs_d.rails_oe = smu_pkg::apply_update(regs_q.rails_oe, frame.val);
        // ina feedback switches
        smu_pkg::addr_ina_vfb_sw:
          regs_d.ina_vfb_sw = smu_pkg::apply_update(regs_q.ina_vfb_sw, frame.val);
        smu_pkg::addr_ina_ifb_sw:
          regs_d.ina_ifb_sw = smu_pkg::apply_update(regs_q.ina_ifb_sw, frame.val);
        smu_pkg::addr_ina_vfb_atten_sw:
          regs_d.ina_vfb_atten_sw =
            smu_pkg::apply_update(regs_q.ina_vfb_atten_sw, frame.val);
        smu_pkg::addr_isense_mux:
          regs_d.isense_mux = smu_pkg::apply_update(regs_q.isense_mux, frame.val);
        // output relays
        smu_pkg::addr_relay_out:
          regs_d.relay_out = smu_pkg::apply_update(regs_q.relay_out, frame.val);
        smu_pkg::addr_relay_vsense:
          regs_d.relay_vsense = smu_pkg::apply_update(regs_q.relay_vsense, frame.val);
        smu_pkg::addr_irange_yz_sw:
          regs_d.irange_yz_sw = smu_pkg::apply_update(regs_q.irange_yz_sw, frame.val);
        // unknown address, frame dropped
        default:
          regs_d = regs_q;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // register bank

  // rst_n loads the same defaults as the soft reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      regs_q <= smu_pkg::CTRL_DEFAULTS;
    end
    else
    begin
      regs_q <= regs_d;
    end
  end

  assign regs = regs_q;

endmodule

//--- spi_frame_rx.sv
/*
  spi frame receiver, mode 0
  brings sck, cs_n and mosi into the clk domain, collects a 16-bit frame
  and shifts the fixed reply word back out msb first
*/
`timescale 1ns/1ps

module spi_frame_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sck,
  input  logic                cs_n,
  input  logic                mosi,
  output smu_pkg::spi_frame_t frame,
  output logic                frame_valid,
  output logic                reply_bit
);

  //////////////////////////////////////////////////
  // synchronisers

  // one extra stage on sck and cs_n for edge detect
  logic [smu_pkg::SYNC_STAGES:0]   sck_sync;
  logic [smu_pkg::SYNC_STAGES:0]   cs_sync;
  logic [smu_pkg::SYNC_STAGES-1:0] mosi_sync;

  logic sck_s;
  logic sck_d;
  logic cs_s;
  logic cs_d;
  logic mosi_s;

  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_rise;
  logic cs_act;

  // saturating count so long frames never wrap back to 16
  logic [$clog2(smu_pkg::FRAME_BITS):0] bit_cnt;
  logic [smu_pkg::FRAME_BITS-1:0]       shift_q;
  logic [smu_pkg::FRAME_BITS-1:0]       reply_q;

  // idle bus is sck low and cs_n high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sck_sync  <= {sck_sync[smu_pkg::SYNC_STAGES-1:0], sck};
      cs_sync   <= {cs_sync[smu_pkg::SYNC_STAGES-1:0], cs_n};
      mosi_sync <= {mosi_sync[smu_pkg::SYNC_STAGES-2:0], mosi};
    end
  end

  assign sck_s  = sck_sync[smu_pkg::SYNC_STAGES-1];
  assign sck_d  = sck_sync[smu_pkg::SYNC_STAGES];
  assign cs_s   = cs_sync[smu_pkg::SYNC_STAGES-1];
  assign cs_d   = cs_sync[smu_pkg::SYNC_STAGES];
  assign mosi_s = mosi_sync[smu_pkg::SYNC_STAGES-1];

  // edges seen in the clk domain
  assign sck_rise = sck_s & ~sck_d;
  assign sck_fall = ~sck_s & sck_d;
  assign cs_fall  = ~cs_s & cs_d;
  assign cs_rise  = cs_s & ~cs_d;
  assign cs_act   = ~cs_s;

  //////////////////////////////////////////////////
  // frame capture

  // mosi into lsb, first bit ends up in addr msb
  always_ff @(posedge clk)
  begin
    if (cs_act && sck_rise)
    begin
      shift_q <= {shift_q[smu_pkg::FRAME_BITS-2:0], mosi_s};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt     <= '0;
      reply_q     <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      // only a frame of exactly 16 bits counts
      frame_valid <= cs_rise &&
                     (bit_cnt == ($clog2(smu_pkg::FRAME_BITS) + 1)'(smu_pkg::FRAME_BITS));
      if (cs_fall)
      begin
        // new frame, reply msb goes out before the first sck
        bit_cnt <= '0;
        reply_q <= smu_pkg::SPI_REPLY;
      end
      else if (cs_act)
      begin
        if (sck_rise && !(&bit_cnt))
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
        // next reply bit on falling sck, zero fill
        if (sck_fall)
        begin
          reply_q <= {reply_q[smu_pkg::FRAME_BITS-2:0], 1'b0};
        end
      end
    end
  end

  assign frame     = shift_q;
  assign reply_bit = reply_q[smu_pkg::FRAME_BITS-1];

endmodule

//--- smu_pkg.sv
/*
  smu control package
  sizes, register addresses, board-safe defaults and the
  set/clear/toggle rule for the 4-bit control registers
*/
package smu_pkg;

  //////////////////////////////////////////////////
  // sizes

  // one control register, always 4 bits wide
  typedef logic [3:0] ctrl_nib_t;

  // downstream spi devices behind cs2
  localparam int NUM_PERIPH = 4;
  // address byte plus value byte
  localparam int FRAME_BITS = 16;
  // flops per synchroniser on the spi pins
  localparam int SYNC_STAGES = 2;

  //////////////////////////////////////////////////
  // frame format

  // high byte of a frame picks the register
  typedef enum logic [7:0] {
    addr_led              = 8'd7,
    addr_periph_sel       = 8'd8,
    addr_dac              = 8'd9,
    addr_rails            = 8'd10,
    addr_soft_reset       = 8'd11,
    addr_dac_ref_mux      = 8'd12,
    addr_adc              = 8'd14,
    addr_clamp1           = 8'd15,
    addr_clamp2           = 8'd16,
    addr_relay_com        = 8'd17,
    addr_irange_x_sw      = 8'd18,
    addr_rails_oe         = 8'd24,
    addr_ina_vfb_sw       = 8'd25,
    addr_ina_ifb_sw       = 8'd28,
    addr_ina_vfb_atten_sw = 8'd29,
    addr_isense_mux       = 8'd30,
    addr_relay_out        = 8'd31,
    addr_relay_vsense     = 8'd32,
    addr_irange_yz_sw     = 8'd33
  } reg_addr_e;

  // first bit on the wire is addr msb
  typedef struct packed {
    logic [7:0] addr;
    // low nibble sets, high nibble clears
    logic [7:0] val;
  } spi_frame_t;

  // fixed word shifted back to the host on every frame
  localparam logic [FRAME_BITS-1:0] SPI_REPLY = 16'hFF00;

  //////////////////////////////////////////////////
  // register bank

  // field order follows the address order
  typedef struct packed {
    ctrl_nib_t led;
    ctrl_nib_t periph_sel;
    ctrl_nib_t dac;
    ctrl_nib_t rails;
    ctrl_nib_t dac_ref_mux;
    ctrl_nib_t adc;
    ctrl_nib_t clamp1;
    ctrl_nib_t clamp2;
    ctrl_nib_t relay_com;
    ctrl_nib_t irange_x_sw;
    ctrl_nib_t rails_oe;
    ctrl_nib_t ina_vfb_sw;
    ctrl_nib_t ina_ifb_sw;
    ctrl_nib_t ina_vfb_atten_sw;
    ctrl_nib_t isense_mux;
    ctrl_nib_t relay_out;
    ctrl_nib_t relay_vsense;
    ctrl_nib_t irange_yz_sw;
  } ctrl_regs_t;

  // board-safe state after rst_n or a soft reset
  // active low switches and clamps sit off at 4'hF
  // rails_oe stays high until the rails are brought up
  localparam ctrl_regs_t CTRL_DEFAULTS = '{
    led:              4'h0,
    periph_sel:       4'h0,
    dac:              4'h0,
    rails:            4'h0,
    dac_ref_mux:      4'hF,
    adc:              4'h0,
    clamp1:           4'hF,
    clamp2:           4'hF,
    relay_com:        4'h0,
    irange_x_sw:      4'h0,
    rails_oe:         4'h1,
    ina_vfb_sw:       4'h0,
    ina_ifb_sw:       4'hF,
    ina_vfb_atten_sw: 4'hF,
    isense_mux:       4'hF,
    relay_out:        4'h0,
    relay_vsense:     4'h0,
    irange_yz_sw:     4'h0
  };

  // set/clear update of one register
  // bits named in both masks toggle, and then the rest of the masks is ignored
  function automatic ctrl_nib_t apply_update(input ctrl_nib_t old, input logic [7:0] val);
    ctrl_nib_t set_m;
    ctrl_nib_t clr_m;
    ctrl_nib_t both_m;
    set_m  = val[3:0];
    clr_m  = val[7:4];
    both_m = set_m & clr_m;
    if (|both_m)
    begin
      return old ^ both_m;
    end
    return (old | set_m) & ~clr_m;
  endfunction

endpackage
